/* hw/mem_map_pkg.sv */
package mem_map_pkg;

    // 64 KB CPU memory map
    //   0x0000 - 0x3FFF  ROM
    //   0x4000 - 0x9FFF  RAM
    //   0xA000           UART status, read only
    //   0xA001           UART data, read pops RX, write pushes TX
    //   0xA002           Result LED, write only

    // First address past the ROM window
    localparam logic [15:0] ROM_LIMIT = 16'h4000;

    // First address past the RAM window
    localparam logic [15:0] RAM_LIMIT = 16'hA000;

    // I/O registers sit just above RAM
    localparam logic [15:0] UART_STATUS_ADDR = 16'hA000;
    localparam logic [15:0] UART_DATA_ADDR   = 16'hA001;
    localparam logic [15:0] LED_ADDR         = 16'hA002;

    // Bit positions inside the UART status byte, all other bits read as zero
    localparam int unsigned STATUS_RX_EMPTY_BIT = 0;
    localparam int unsigned STATUS_TX_FULL_BIT  = 1;

    // Kind of access accepted from the bus
    typedef enum logic [2:0] {
        KIND_NONE        = 3'd0,
        KIND_ROM         = 3'd1,
        KIND_RAM         = 3'd2,
        KIND_UART_RX     = 3'd3,
        KIND_UART_TX     = 3'd4,
        KIND_UART_STATUS = 3'd5,
        KIND_LED         = 3'd6
    } access_kind_t;

endpackage

/* hw/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode
    import mem_map_pkg::*;
#(
    parameter int ADDR_WIDTH     = 16,
    parameter int ROM_ADDR_WIDTH = 14,
    parameter int RAM_ADDR_WIDTH = 15
) (
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [ADDR_WIDTH-1:0]     i_wb_addr,
    output access_kind_t              o_kind,
    output logic [ROM_ADDR_WIDTH-1:0] o_rom_addr,
    output logic [RAM_ADDR_WIDTH-1:0] o_ram_addr
);

    logic                  req_valid;
    logic                  in_rom;
    logic                  in_ram;
    logic                  at_status;
    logic                  at_data;
    logic                  at_led;
    logic [ADDR_WIDTH-1:0] ram_offset;

    // A request counts only while both strobe and cycle are high
    assign req_valid = i_wb_cyc && i_wb_stb;

    // Address windows
    assign in_rom    = i_wb_addr < ROM_LIMIT;
    assign in_ram    = (i_wb_addr >= ROM_LIMIT) && (i_wb_addr < RAM_LIMIT);
    assign at_status = i_wb_addr == UART_STATUS_ADDR;
    assign at_data   = i_wb_addr == UART_DATA_ADDR;
    assign at_led    = i_wb_addr == LED_ADDR;

    // Pick one access kind; illegal combinations fall through to KIND_NONE
    always_comb begin
        o_kind = KIND_NONE;
        if (req_valid) begin
            if (in_rom) begin
                o_kind = KIND_ROM;
            end else if (in_ram) begin
                o_kind = KIND_RAM;
            end else if (at_status && !i_wb_we) begin
                // Status is read only, a write here is dropped without ack
                o_kind = KIND_UART_STATUS;
            end else if (at_data) begin
                o_kind = i_wb_we ? KIND_UART_TX : KIND_UART_RX;
            end else if (at_led && i_wb_we) begin
                o_kind = KIND_LED;
            end
        end
    end

    // Block RAMs register the address themselves, so these stay combinational
    assign o_rom_addr = i_wb_addr[ROM_ADDR_WIDTH-1:0];

    // RAM window starts at ROM_LIMIT, rebase to zero
    assign ram_offset = i_wb_addr - ADDR_WIDTH'(ROM_LIMIT);
    assign o_ram_addr = ram_offset[RAM_ADDR_WIDTH-1:0];

endmodule

/* hw/access_dispatch.sv */
`timescale 1ns/1ps

module access_dispatch
    import mem_map_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  access_kind_t          i_kind,
    input  logic                  i_wb_we,
    input  logic [DATA_WIDTH-1:0] i_wb_data,
    output access_kind_t          o_pending_kind,
    output logic                  o_rom_stb,
    output logic                  o_ram_stb,
    output logic                  o_ram_wr,
    output logic                  o_rx_stb,
    output logic                  o_tx_stb,
    output logic                  o_led,
    output logic [DATA_WIDTH-1:0] o_ram_data,
    output logic [DATA_WIDTH-1:0] o_tx_data
);

    access_kind_t          pending_kind;
    logic                  ram_wr_q;
    logic                  led_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic                  is_write_target;

    // Pending stage, one access per cycle and no stall
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            pending_kind <= KIND_NONE;
            ram_wr_q     <= 1'b0;
        end else begin
            pending_kind <= i_kind;
            ram_wr_q     <= (i_kind == KIND_RAM) && i_wb_we;
        end
    end

    // LED follows bit 0 of the last write to LED_ADDR
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            led_q <= 1'b0;
        end else if (i_kind == KIND_LED) begin
            led_q <= i_wb_data[0];
        end
    end

    // RAM and TX never take data in the same cycle, so they share one register
    assign is_write_target = (i_kind == KIND_RAM) || (i_kind == KIND_UART_TX);

    always_ff @(posedge i_clk) begin
        if (is_write_target) begin
            wdata_q <= i_wb_data;
        end
    end

    // Strobes come straight from the pending kind, hence one-hot by construction
    assign o_rom_stb = pending_kind == KIND_ROM;
    assign o_ram_stb = pending_kind == KIND_RAM;
    assign o_rx_stb  = pending_kind == KIND_UART_RX;
    assign o_tx_stb  = pending_kind == KIND_UART_TX;
    assign o_ram_wr  = ram_wr_q;

    assign o_pending_kind = pending_kind;
    assign o_led          = led_q;
    assign o_ram_data     = wdata_q;
    assign o_tx_data      = wdata_q;

endmodule

/* hw/read_return.sv */
`timescale 1ns/1ps

module read_return
    import mem_map_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  access_kind_t          i_pending_kind,
    input  logic [DATA_WIDTH-1:0] i_rom_data,
    input  logic [DATA_WIDTH-1:0] i_ram_data,
    input  logic [DATA_WIDTH-1:0] i_rx_data,
    input  logic                  i_tx_full,
    input  logic                  i_rx_empty,
    output logic                  o_wb_ack,
    output logic [DATA_WIDTH-1:0] o_wb_data
);

    logic [DATA_WIDTH-1:0] status_q;

    // Status snapshot taken every edge, so a read sees the flags at acceptance
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            status_q <= '0;
        end else begin
            status_q                      <= '0;
            status_q[STATUS_TX_FULL_BIT]  <= i_tx_full;
            status_q[STATUS_RX_EMPTY_BIT] <= i_rx_empty;
        end
    end

    // Read data mux, writes and LED return zero
    always_comb begin
        case (i_pending_kind)
            KIND_ROM: begin
                o_wb_data = i_rom_data;
            end
            KIND_RAM: begin
                o_wb_data = i_ram_data;
            end
            KIND_UART_RX: begin
                o_wb_data = i_rx_data;
            end
            KIND_UART_STATUS: begin
                o_wb_data = status_q;
            end
            default: begin
                o_wb_data = '0;
            end
        endcase
    end

    // Every accepted access is answered in the cycle after acceptance
    assign o_wb_ack = i_pending_kind != KIND_NONE;

endmodule

/* hw/mem_bus_adapter.sv */
`timescale 1ns/1ps

module mem_bus_adapter
    import mem_map_pkg::*;
#(
    parameter int DATA_WIDTH     = 8,
    parameter int ADDR_WIDTH     = 16,
    parameter int ROM_ADDR_WIDTH = 14,
    parameter int RAM_ADDR_WIDTH = 15
) (
    input  logic                      i_clk,
    input  logic                      i_reset_n,

    // CPU side bus
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [ADDR_WIDTH-1:0]     i_wb_addr,
    input  logic [DATA_WIDTH-1:0]     i_wb_data,
    output logic                      o_wb_ack,
    output logic [DATA_WIDTH-1:0]     o_wb_data,

    // ROM
    output logic [ROM_ADDR_WIDTH-1:0] o_rom_addr,
    output logic                      o_rom_stb,
    input  logic [DATA_WIDTH-1:0]     i_rom_data,

    // RAM
    output logic [RAM_ADDR_WIDTH-1:0] o_ram_addr,
    output logic                      o_ram_stb,
    output logic                      o_ram_wr,
    output logic [DATA_WIDTH-1:0]     o_ram_data,
    input  logic [DATA_WIDTH-1:0]     i_ram_data,

    // UART RX FIFO
    output logic                      o_rx_stb,
    input  logic [DATA_WIDTH-1:0]     i_rx_data,
    input  logic                      i_rx_empty,

    // UART TX FIFO
    output logic                      o_tx_stb,
    output logic [DATA_WIDTH-1:0]     o_tx_data,
    input  logic                      i_tx_full,

    output logic                      o_led
);

    access_kind_t req_kind;
    access_kind_t pending_kind;

    // Stage 1, classify the request in its own cycle
    bus_decode #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH),
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_bus_decode (
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_addr  (i_wb_addr),
        .o_kind     (req_kind),
        .o_rom_addr (o_rom_addr),
        .o_ram_addr (o_ram_addr)
    );

    // Stage 2, register the access and fire the target strobe
    access_dispatch #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_access_dispatch (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_kind         (req_kind),
        .i_wb_we        (i_wb_we),
        .i_wb_data      (i_wb_data),
        .o_pending_kind (pending_kind),
        .o_rom_stb      (o_rom_stb),
        .o_ram_stb      (o_ram_stb),
        .o_ram_wr       (o_ram_wr),
        .o_rx_stb       (o_rx_stb),
        .o_tx_stb       (o_tx_stb),
        .o_led          (o_led),
        .o_ram_data     (o_ram_data),
        .o_tx_data      (o_tx_data)
    );

    // Answer the pending access, overlapping with the next decode
    read_return #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_read_return (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_pending_kind (pending_kind),
        .i_rom_data     (i_rom_data),
        .i_ram_data     (i_ram_data),
        .i_rx_data      (i_rx_data),
        .i_tx_full      (i_tx_full),
        .i_rx_empty     (i_rx_empty),
        .o_wb_ack       (o_wb_ack),
        .o_wb_data      (o_wb_data)
    );

endmodule

/* verif/mem_bus_adapter_assertions.sv */
`timescale 1ns/1ps

module mem_bus_adapter_assertions
    import mem_map_pkg::*;
#(
    parameter int DATA_WIDTH     = 8,
    parameter int ADDR_WIDTH     = 16,
    parameter int ROM_ADDR_WIDTH = 14,
    parameter int RAM_ADDR_WIDTH = 15
) (
    input logic                      i_clk,
    input logic                      i_reset_n,
    input logic                      i_wb_cyc,
    input logic                      i_wb_stb,
    input logic                      i_wb_we,
    input logic [ADDR_WIDTH-1:0]     i_wb_addr,
    input logic [DATA_WIDTH-1:0]     i_wb_data,
    input logic                      i_wb_ack,
    input logic [DATA_WIDTH-1:0]     i_wb_rdata,
    input logic [ROM_ADDR_WIDTH-1:0] i_rom_addr,
    input logic                      i_rom_stb,
    input logic [DATA_WIDTH-1:0]     i_rom_data,
    input logic [RAM_ADDR_WIDTH-1:0] i_ram_addr,
    input logic                      i_ram_stb,
    input logic                      i_ram_wr,
    input logic [DATA_WIDTH-1:0]     i_ram_wdata,
    input logic [DATA_WIDTH-1:0]     i_ram_data,
    input logic                      i_rx_stb,
    input logic [DATA_WIDTH-1:0]     i_rx_data,
    input logic                      i_rx_empty,
    input logic                      i_tx_stb,
    input logic [DATA_WIDTH-1:0]     i_tx_wdata,
    input logic                      i_tx_full,
    input logic                      i_led
);

    logic                  prev_valid;
    logic                  prev_we;
    logic [ADDR_WIDTH-1:0] prev_addr;
    logic [DATA_WIDTH-1:0] prev_data;
    logic                  prev_tx_full;
    logic                  prev_rx_empty;
    logic                  led_model;
    logic                  exp_ack;
    // Order is rom, ram, ram_wr, rx, tx
    logic [4:0]            exp_strobes;
    logic [DATA_WIDTH-1:0] exp_rdata;
    logic                  exp_rdata_known;
    logic                  req_valid;
    int                    error_count = 0;
    // Name of the running test, set by the testbench
    string                 test_name = "";

    assign req_valid = i_wb_cyc && i_wb_stb;

    // Shadow of the request and status flags seen at the last edge
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            prev_valid    <= 1'b0;
            prev_we       <= 1'b0;
            prev_addr     <= '0;
            prev_data     <= '0;
            prev_tx_full  <= 1'b0;
            prev_rx_empty <= 1'b0;
            led_model     <= 1'b0;
        end else begin
            prev_valid    <= req_valid;
            prev_we       <= i_wb_we;
            prev_addr     <= i_wb_addr;
            prev_data     <= i_wb_data;
            prev_tx_full  <= i_tx_full;
            prev_rx_empty <= i_rx_empty;
            if (req_valid && i_wb_we && (i_wb_addr == LED_ADDR)) begin
                led_model <= i_wb_data[0];
            end
        end
    end

    // Expected answer for the request taken at the last edge
    always_comb begin
        exp_ack         = 1'b0;
        exp_strobes     = '0;
        exp_rdata       = '0;
        exp_rdata_known = 1'b0;
        if (prev_valid) begin
            if (prev_addr < ROM_LIMIT) begin
                exp_ack         = 1'b1;
                exp_strobes     = 5'b10000;
                exp_rdata       = i_rom_data;
                exp_rdata_known = !prev_we;
            end else if (prev_addr < RAM_LIMIT) begin
                exp_ack         = 1'b1;
                exp_strobes     = {2'b01, prev_we, 2'b00};
                exp_rdata       = i_ram_data;
                exp_rdata_known = !prev_we;
            end else if ((prev_addr == UART_STATUS_ADDR) && !prev_we) begin
                exp_ack                        = 1'b1;
                exp_rdata_known                = 1'b1;
                exp_rdata[STATUS_TX_FULL_BIT]  = prev_tx_full;
                exp_rdata[STATUS_RX_EMPTY_BIT] = prev_rx_empty;
            end else if (prev_addr == UART_DATA_ADDR) begin
                exp_ack         = 1'b1;
                exp_strobes     = prev_we ? 5'b00001 : 5'b00010;
                exp_rdata       = prev_we ? '0 : i_rx_data;
                exp_rdata_known = 1'b1;
            end else if ((prev_addr == LED_ADDR) && prev_we) begin
                exp_ack         = 1'b1;
                exp_rdata_known = 1'b1;
            end
        end
    end

    reset_idle_a: assert property (@(posedge i_clk)
        !i_reset_n |=> !(i_wb_ack || i_rom_stb || i_ram_stb || i_ram_wr || i_rx_stb
                         || i_tx_stb || i_led))
        else begin
            error_count++;
            $error("outputs not idle in the cycle after a reset edge");
        end

    ack_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_wb_ack == exp_ack)
        else begin
            error_count++;
            $error("mismatch in %s on ack: expected %0b, actual %0b", test_name,
                   $sampled(exp_ack), $sampled(i_wb_ack));
        end

    strobes_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        {i_rom_stb, i_ram_stb, i_ram_wr, i_rx_stb, i_tx_stb} == exp_strobes)
        else begin
            error_count++;
            $error("mismatch in %s on strobes: expected %b, actual %b", test_name,
                   $sampled(exp_strobes),
                   $sampled({i_rom_stb, i_ram_stb, i_ram_wr, i_rx_stb, i_tx_stb}));
        end

    one_hot_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $onehot0({i_rom_stb, i_ram_stb, i_rx_stb, i_tx_stb}))
        else begin
            error_count++;
            $error("more than one target strobe high");
        end

    // Every read returns its data, TX and LED writes return zero
    rdata_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        exp_rdata_known |-> (i_wb_rdata == exp_rdata))
        else begin
            error_count++;
            $error("mismatch in %s on read data: expected %h, actual %h", test_name,
                   $sampled(exp_rdata), $sampled(i_wb_rdata));
        end

    ram_wdata_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        exp_strobes[2] |-> (i_ram_wdata == prev_data))
        else begin
            error_count++;
            $error("mismatch in %s on ram write data: expected %h, actual %h", test_name,
                   $sampled(prev_data), $sampled(i_ram_wdata));
        end

    tx_wdata_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        exp_strobes[0] |-> (i_tx_wdata == prev_data))
        else begin
            error_count++;
            $error("mismatch in %s on tx write data: expected %h, actual %h", test_name,
                   $sampled(prev_data), $sampled(i_tx_wdata));
        end

    led_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_led == led_model)
        else begin
            error_count++;
            $error("mismatch in %s on led: expected %0b, actual %0b", test_name,
                   $sampled(led_model), $sampled(i_led));
        end

    // Memory addresses map back onto the request address
    rom_addr_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (req_valid && (i_wb_addr < ROM_LIMIT)) |-> (ADDR_WIDTH'(i_rom_addr) == i_wb_addr))
        else begin
            error_count++;
            $error("mismatch in %s on rom address: expected %h, actual %h", test_name,
                   $sampled(i_wb_addr), $sampled(i_rom_addr));
        end

    ram_addr_a: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (req_valid && (i_wb_addr >= ROM_LIMIT) && (i_wb_addr < RAM_LIMIT))
        |-> ((ADDR_WIDTH'(i_ram_addr) + ROM_LIMIT) == i_wb_addr))
        else begin
            error_count++;
            $error("mismatch in %s on ram address: expected %h, actual %h", test_name,
                   $sampled(i_wb_addr) - ROM_LIMIT, $sampled(i_ram_addr));
        end

endmodule

bind mem_bus_adapter mem_bus_adapter_assertions #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH),
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
) u_checker (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_addr   (i_wb_addr),
    .i_wb_data   (i_wb_data),
    .i_wb_ack    (o_wb_ack),
    .i_wb_rdata  (o_wb_data),
    .i_rom_addr  (o_rom_addr),
    .i_rom_stb   (o_rom_stb),
    .i_rom_data  (i_rom_data),
    .i_ram_addr  (o_ram_addr),
    .i_ram_stb   (o_ram_stb),
    .i_ram_wr    (o_ram_wr),
    .i_ram_wdata (o_ram_data),
    .i_ram_data  (i_ram_data),
    .i_rx_stb    (o_rx_stb),
    .i_rx_data   (i_rx_data),
    .i_rx_empty  (i_rx_empty),
    .i_tx_stb    (o_tx_stb),
    .i_tx_wdata  (o_tx_data),
    .i_tx_full   (i_tx_full),
    .i_led       (o_led)
);

/* verif/tb_mem_bus_adapter.sv */
`timescale 1ns/1ps

module tb_mem_bus_adapter
    import mem_map_pkg::*;
();

    localparam int DATA_WIDTH      = 8;
    localparam int ADDR_WIDTH      = 16;
    localparam int ROM_ADDR_WIDTH  = 14;
    localparam int RAM_ADDR_WIDTH  = 15;
    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int RANDOM_REQUESTS = 300;
    // Directed tests need well under 60 cycles
    localparam int TEST_CYCLES     = RESET_CYCLES + 60 + RANDOM_REQUESTS;
    localparam int TIMEOUT_NS      = TEST_CYCLES * CLK_PERIOD + 200;

    logic                      clk;
    logic                      reset_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [ADDR_WIDTH-1:0]     wb_addr;
    logic [DATA_WIDTH-1:0]     wb_data;
    logic                      wb_ack;
    logic [DATA_WIDTH-1:0]     wb_rdata;
    logic [ROM_ADDR_WIDTH-1:0] rom_addr;
    logic                      rom_stb;
    logic [DATA_WIDTH-1:0]     rom_data;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                      ram_stb;
    logic                      ram_wr;
    logic [DATA_WIDTH-1:0]     ram_wdata;
    logic [DATA_WIDTH-1:0]     ram_data;
    logic                      rx_stb;
    logic [DATA_WIDTH-1:0]     rx_data;
    logic                      rx_empty;
    logic                      tx_stb;
    logic [DATA_WIDTH-1:0]     tx_wdata;
    logic                      tx_full;
    logic                      led;

    integer seed = 44;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     errors_before = 0;

    mem_bus_adapter #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH),
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) DUT (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_data),
        .o_wb_ack   (wb_ack),
        .o_wb_data  (wb_rdata),
        .o_rom_addr (rom_addr),
        .o_rom_stb  (rom_stb),
        .i_rom_data (rom_data),
        .o_ram_addr (ram_addr),
        .o_ram_stb  (ram_stb),
        .o_ram_wr   (ram_wr),
        .o_ram_data (ram_wdata),
        .i_ram_data (ram_data),
        .o_rx_stb   (rx_stb),
        .i_rx_data  (rx_data),
        .i_rx_empty (rx_empty),
        .o_tx_stb   (tx_stb),
        .o_tx_data  (tx_wdata),
        .i_tx_full  (tx_full),
        .o_led      (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory and FIFO models present fresh values every cycle
    always @(negedge clk) begin
        rom_data = DATA_WIDTH'($random(seed));
        ram_data = DATA_WIDTH'($random(seed));
        rx_data  = DATA_WIDTH'($random(seed));
        tx_full  = 1'($random(seed));
        rx_empty = 1'($random(seed));
    end

    task automatic drive_bus(input logic cyc, input logic stb, input logic we,
                             input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data);
        @(negedge clk);
        wb_cyc  = cyc;
        wb_stb  = stb;
        wb_we   = we;
        wb_addr = addr;
        wb_data = data;
    endtask

    task automatic request(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data);
        drive_bus(1'b1, 1'b1, we, addr, data);
    endtask

    // The checker names this test in its mismatch lines
    task automatic start_test(input string name);
        DUT.u_checker.test_name = name;
    endtask

    // Two idle cycles let the last ack reach its check
    task automatic close_test();
        int new_errors;
        repeat (2) begin
            drive_bus(1'b0, 1'b0, 1'b0, '0, '0);
        end
        new_errors = DUT.u_checker.error_count - errors_before;
        errors_before = DUT.u_checker.error_count;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s: ok", DUT.u_checker.test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d assertion failures", DUT.u_checker.test_name,
                     new_errors);
        end
    endtask

    // Spread random requests over every window and a few unmapped addresses
    function automatic logic [ADDR_WIDTH-1:0] random_address(input logic [31:0] r);
        case (r[2:0])
            3'd0, 3'd1: return {2'b00, r[16:3]};
            3'd2, 3'd3: return ROM_LIMIT + 16'(r[30:16] % 15'h6000);
            3'd4:       return UART_STATUS_ADDR;
            3'd5:       return UART_DATA_ADDR;
            3'd6:       return LED_ADDR;
            default:    return r[31:16];
        endcase
    endfunction

    initial begin
        logic [31:0] r;
        clk      = 1'b0;
        reset_n  = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        rom_data = '0;
        ram_data = '0;
        rx_data  = '0;
        tx_full  = 1'b0;
        rx_empty = 1'b1;

        start_test("reset_state");
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        close_test();

        start_test("rom_read");
        request(1'b0, 16'h1234, '0);
        request(1'b0, 16'h3FFF, '0);
        close_test();
        start_test("ram_read");
        request(1'b0, 16'h4000, '0);
        request(1'b0, 16'h9FFF, '0);
        close_test();
        start_test("rx_read");
        request(1'b0, UART_DATA_ADDR, '0);
        close_test();

        start_test("ram_write");
        request(1'b1, 16'h4321, 8'hC3);
        request(1'b1, 16'h9FFF, 8'h3C);
        close_test();
        start_test("tx_write");
        request(1'b1, UART_DATA_ADDR, 8'hA5);
        close_test();

        start_test("status_read");
        repeat (6) begin
            request(1'b0, UART_STATUS_ADDR, '0);
        end
        close_test();

        start_test("led_write");
        request(1'b1, LED_ADDR, 8'h01);
        request(1'b1, LED_ADDR, 8'hFE);
        request(1'b1, LED_ADDR, 8'h03);
        close_test();

        start_test("no_ack");
        request(1'b0, LED_ADDR, '0);
        request(1'b1, UART_STATUS_ADDR, 8'hFF);
        request(1'b0, 16'hA003, '0);
        request(1'b1, 16'hFFFF, 8'h55);
        drive_bus(1'b0, 1'b1, 1'b0, 16'h0100, '0);
        drive_bus(1'b1, 1'b0, 1'b1, 16'h5000, 8'h77);
        close_test();

        start_test("back_to_back");
        for (int i = 0; i < RANDOM_REQUESTS; i++) begin
            r = $random(seed);
            // Mostly active cycles, with an occasional idle one
            drive_bus(r[31:29] != 3'd0, r[28:26] != 3'd0, r[25],
                      random_address($random(seed)), r[DATA_WIDTH-1:0]);
        end
        close_test();

        $display("tests run: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_run, tests_failed, DUT.u_checker.error_count);
        if (tests_failed == 0 && DUT.u_checker.error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog.f */
hw/mem_map_pkg.sv
hw/bus_decode.sv
hw/access_dispatch.sv
hw/read_return.sv
hw/mem_bus_adapter.sv
verif/mem_bus_adapter_assertions.sv
verif/tb_mem_bus_adapter.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_mem_bus_adapter
FILELIST  := verilog.f
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
